// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/hwloop_pkg.sv
      - hw/instr_fifo.sv
      - hw/prefetch_buffer.sv
      - hw/hwloop_regs.sv
      - hw/fetch_top.sv
  - target: simulation
    files:
      - bench/fetch_top_tb.sv

// ==== bench/fetch_top_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch front end testbench
// random latency memory model and a scenario table of branches, loops,
// back-pressure and access errors, checked against an address model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_top_tb;
  import fetch_pkg::*;
  import hwloop_pkg::*;

  localparam int unsigned FIFO_DEPTH = 2;
  localparam instr_data_t PATTERN    = 32'hA5A5_0F0F;
  // every word at or above this address returns an access error
  localparam instr_addr_t ERR_BASE   = 32'h0000_8000;
  localparam int          TIMEOUT    = 200;
  localparam int          N_ROWS     = 6;

  // one scenario row
  typedef struct packed {
    instr_addr_t br_addr;
    instr_addr_t lp_start;
    instr_addr_t lp_end;
    hwlp_count_t lp_count;
    logic [7:0]  n_instr;
    logic        rnd_ready;
    logic        exp_err;
  } scen_t;

  logic         clk        = 1'b0;
  logic         rst_n      = 1'b0;
  logic         req_i      = 1'b0;
  logic         branch_i   = 1'b0;
  instr_addr_t  addr_i     = '0;
  logic         ready_i    = 1'b0;
  imem_rsp_t    imem_rsp_i = '0;
  hwlp_cfg_wr_t cfg_wr_i   = '0;
  fetch_out_t   out_o;
  imem_req_t    imem_req_o;
  logic         fetch_failed_o;
  logic         busy_o;
  hwlp_count_t  hwlp_count_o;

  scen_t        scen [N_ROWS];
  int           n_checks  = 0;
  int           n_errors  = 0;
  // memory model state
  logic         mem_busy  = 1'b0;
  int           mem_lat   = 0;
  int           mem_gwait = 0;
  instr_addr_t  mem_addr  = '0;

  initial begin
    forever #5 clk = ~clk;
  end

  fetch_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fetch_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_i         (addr_i),
    .ready_i        (ready_i),
    .out_o          (out_o),
    .imem_req_o     (imem_req_o),
    .imem_rsp_i     (imem_rsp_i),
    .cfg_wr_i       (cfg_wr_i),
    .fetch_failed_o (fetch_failed_o),
    .busy_o         (busy_o),
    .hwlp_count_o   (hwlp_count_o)
  );

  task automatic check_equal(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    n_checks++;
    if (exp_val !== act_val) begin
      n_errors++;
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction memory model
  ////////////////////////////////////////////////////////////////////////////

  // one request outstanding, grant after 0..2 request cycles,
  // rvalid 1..3 cycles after the grant
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_busy   = 1'b0;
      mem_gwait  = 0;
      imem_rsp_i <= '0;
    end else begin
      if (imem_req_o.req && imem_rsp_i.gnt) begin
        // fetch is word aligned
        check_equal("imem_req_o.addr[1:0]", 0, imem_req_o.addr[1:0]);
        mem_busy  = 1'b1;
        mem_lat   = 1 + $urandom % 3;
        mem_addr  = imem_req_o.addr;
        mem_gwait = $urandom % 3;
      end else if (imem_req_o.req && mem_gwait != 0) begin
        mem_gwait = mem_gwait - 1;
      end
      imem_rsp_i.rvalid <= 1'b0;
      imem_rsp_i.err    <= 1'b0;
      if (mem_busy) begin
        mem_lat = mem_lat - 1;
        if (mem_lat == 0) begin
          mem_busy = 1'b0;
          imem_rsp_i.rvalid <= 1'b1;
          imem_rsp_i.err    <= (mem_addr >= ERR_BASE);
        end
      end
      imem_rsp_i.rdata <= mem_addr ^ PATTERN;
      // the next request may be granted in the cycle of the rvalid
      imem_rsp_i.gnt   <= !mem_busy && mem_gwait == 0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // scenarios
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          got;
    int          waited;
    int          model_cnt;
    instr_addr_t model_pc;
    logic        aborted;
    aborted = 1'b0;
    void'($urandom(25));
    // branch addr, loop start, loop end, loop count, words, random ready, error
    scen[0] = {32'h0000_0200, 32'h0, 32'h0, 16'd0, 8'd8, 1'b0, 1'b0};
    scen[1] = {32'h0000_0400, 32'h0, 32'h0, 16'd0, 8'd6, 1'b1, 1'b0};
    scen[2] = {32'h0000_0100, 32'h0000_0108, 32'h0000_0110, 16'd3, 8'd13, 1'b0, 1'b0};
    scen[3] = {32'h0000_0100, 32'h0000_0108, 32'h0000_0110, 16'd3, 8'd13, 1'b1, 1'b0};
    scen[4] = {ERR_BASE - 32'd12, 32'h0, 32'h0, 16'd0, 8'd3, 1'b0, 1'b1};
    scen[5] = {32'h0000_0600, 32'h0, 32'h0, 16'd0, 8'd5, 1'b0, 1'b0};

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // idle out of reset, no request yet
    check_equal("out_o.valid", 0, out_o.valid);
    check_equal("imem_req_o.req", 0, imem_req_o.req);
    check_equal("fetch_failed_o", 0, fetch_failed_o);
    check_equal("busy_o", 0, busy_o);

    for (int r = 0; r < N_ROWS && !aborted; r++) begin
      // loop config, consumer stalled meanwhile
      cfg_wr_i.we  <= 1'b1;
      cfg_wr_i.cfg <= {scen[r].lp_start, scen[r].lp_end, scen[r].lp_count};
      ready_i      <= 1'b0;
      @(posedge clk);
      cfg_wr_i.we <= 1'b0;
      branch_i    <= 1'b1;
      addr_i      <= scen[r].br_addr;
      req_i       <= 1'b1;
      @(posedge clk);
      branch_i  <= 1'b0;
      ready_i   <= !scen[r].rnd_ready || ($urandom % 2) != 0;
      model_pc  = scen[r].br_addr;
      model_cnt = scen[r].lp_count;
      got       = 0;
      waited    = 0;
      while (got < scen[r].n_instr && waited < TIMEOUT) begin
        @(posedge clk);
        if (out_o.valid && ready_i) begin
          check_equal("out_o.rdata", model_pc ^ PATTERN, out_o.rdata);
          got++;
          waited = 0;
          // at the loop end, jump back while passes remain
          if (model_pc == scen[r].lp_end && model_cnt != 0) begin
            model_cnt--;
            model_pc = (model_cnt != 0) ? scen[r].lp_start : model_pc + 32'd4;
          end else begin
            model_pc = model_pc + 32'd4;
          end
        end else begin
          waited++;
        end
        ready_i <= got < scen[r].n_instr && (!scen[r].rnd_ready || ($urandom % 2) != 0);
      end
      if (got < scen[r].n_instr) begin
        $display("timeout: row %0d got %0d of %0d instructions", r, got, scen[r].n_instr);
        n_errors++;
        aborted = 1'b1;
      end else if (scen[r].exp_err) begin
        // nothing may be offered until the stop shows
        waited = 0;
        do begin
          @(posedge clk);
          waited++;
          if (out_o.valid) begin
            $display("error: row %0d offered an instruction after the last good word", r);
            n_errors++;
          end
        end while (!fetch_failed_o && waited < TIMEOUT);
        if (!fetch_failed_o) begin
          $display("timeout: row %0d never raised fetch_failed_o", r);
          n_errors++;
          aborted = 1'b1;
        end else begin
          repeat (4) begin
            @(posedge clk);
            check_equal("fetch_failed_o", 1, fetch_failed_o);
            check_equal("out_o.valid", 0, out_o.valid);
          end
        end
      end else begin
        @(posedge clk);
        check_equal("fetch_failed_o", 0, fetch_failed_o);
        check_equal("hwlp_count_o", model_cnt, hwlp_count_o);
      end
    end

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/fetch_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch types
// memory request/response and instruction stream structs shared by the
// prefetch buffer, the instruction FIFO and the fetch top level
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  // byte address, fetch is always word aligned
  typedef logic [31:0] instr_addr_t;

  // one 32-bit instruction word
  typedef logic [31:0] instr_data_t;

  // toward instruction memory
  typedef struct packed {
    logic        req;
    instr_addr_t addr;
  } imem_req_t;

  // from instruction memory
  // exactly one rvalid per granted request, in order
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    instr_data_t rdata;
    // access error, only meaningful together with rvalid
    logic        err;
  } imem_rsp_t;

  // toward the consumer (decode), taken on valid && ready
  typedef struct packed {
    logic        valid;
    instr_data_t rdata;
  } fetch_out_t;

endpackage

// ==== hw/fetch_top.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch front end
// prefetch buffer with its instruction FIFO plus the hardware loop block
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_top #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_i,
  input  logic                     branch_i,
  input  fetch_pkg::instr_addr_t   addr_i,
  input  logic                     ready_i,
  output fetch_pkg::fetch_out_t    out_o,
  output fetch_pkg::imem_req_t     imem_req_o,
  input  fetch_pkg::imem_rsp_t     imem_rsp_i,
  input  hwloop_pkg::hwlp_cfg_wr_t cfg_wr_i,
  output logic                     fetch_failed_o,
  output logic                     busy_o,
  output hwloop_pkg::hwlp_count_t  hwlp_count_o
);
  import fetch_pkg::*;

  logic        accept, hwlp_branch;
  instr_addr_t hwlp_target;

  // instruction taken by the consumer
  assign accept = out_o.valid & ready_i;

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_prefetch_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_i         (addr_i),
    .hwlp_branch_i  (hwlp_branch),
    .hwlp_target_i  (hwlp_target),
    .ready_i        (ready_i),
    .out_o          (out_o),
    .imem_req_o     (imem_req_o),
    .imem_rsp_i     (imem_rsp_i),
    .fetch_failed_o (fetch_failed_o),
    .busy_o         (busy_o)
  );

  hwloop_regs i_hwloop_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_wr_i      (cfg_wr_i),
    .branch_i      (branch_i),
    .branch_addr_i (addr_i),
    .accept_i      (accept),
    .hwlp_branch_o (hwlp_branch),
    .hwlp_target_o (hwlp_target),
    .count_o       (hwlp_count_o)
  );

endmodule

// ==== hw/hwloop_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// hardware loop types
// loop configuration and iteration count for the single hardware loop
////////////////////////////////////////////////////////////////////////////

package hwloop_pkg;

  localparam int unsigned HWLP_CNT_W = 16;

  typedef logic [HWLP_CNT_W-1:0] hwlp_count_t;

  typedef struct packed {
    fetch_pkg::instr_addr_t start_addr;
    fetch_pkg::instr_addr_t end_addr;
    hwlp_count_t            count;
  } hwlp_cfg_t;

  // one write loads start, end and count together
  typedef struct packed {
    logic      we;
    hwlp_cfg_t cfg;
  } hwlp_cfg_wr_t;

endpackage

// ==== hw/hwloop_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// hardware loop registers
// one loop: holds start, end and count, tracks the address of the next
// accepted instruction and pulses a loop branch at the loop end
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hwloop_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  hwloop_pkg::hwlp_cfg_wr_t cfg_wr_i,
  input  logic                     branch_i,
  input  fetch_pkg::instr_addr_t   branch_addr_i,
  input  logic                     accept_i,
  output logic                     hwlp_branch_o,
  output fetch_pkg::instr_addr_t   hwlp_target_o,
  output hwloop_pkg::hwlp_count_t  count_o
);
  import fetch_pkg::*;
  import hwloop_pkg::*;

  hwlp_cfg_t   cfg_q;
  instr_addr_t pc_q;
  logic        end_hit;

  // accepted instruction sits at the loop end
  assign end_hit = accept_i & (pc_q == cfg_q.end_addr);

  // last pass falls through, so count 1 only decrements
  assign hwlp_branch_o = end_hit & (cfg_q.count > hwlp_count_t'(1));
  assign hwlp_target_o = cfg_q.start_addr;
  assign count_o       = cfg_q.count;

  // configuration, a write takes effect the next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (cfg_wr_i.we) begin
      cfg_q <= cfg_wr_i.cfg;
    end else if (end_hit && cfg_q.count != '0) begin
      cfg_q.count <= cfg_q.count - hwlp_count_t'(1);
    end
  end

  // address of the next instruction the consumer will take
  // follows the same redirects as the prefetch buffer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (branch_i) begin
      pc_q <= branch_addr_i;
    end else if (hwlp_branch_o) begin
      pc_q <= cfg_q.start_addr;
    end else if (accept_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

endmodule

// ==== hw/instr_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction FIFO
// circular buffer of instruction words with flush and usage count,
// head entry shown on data_o without fall-through
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module instr_fifo #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             flush_i,
  input  logic                             push_i,
  input  logic                             pop_i,
  input  fetch_pkg::instr_data_t           data_i,
  output fetch_pkg::instr_data_t           data_o,
  output logic                             empty_o,
  output logic                             full_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]  usage_o
);
  import fetch_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  instr_data_t      mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push, do_pop;

  // wrap explicitly, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(FIFO_DEPTH));
  assign usage_o = cnt_q;
  assign data_o  = mem_q[rd_ptr_q];

  // overflow and underflow requests are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // flush wins over a push in the same cycle
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push && !flush_i) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// ==== hw/prefetch_buffer.sv ====
////////////////////////////////////////////////////////////////////////////
// prefetch buffer
// issues word fetches over req/gnt/rvalid, rides out branch and loop
// aborts, stops on access errors and queues words in a short FIFO
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module prefetch_buffer #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  fetch_pkg::instr_addr_t addr_i,
  input  logic                   hwlp_branch_i,
  input  fetch_pkg::instr_addr_t hwlp_target_i,
  input  logic                   ready_i,
  output fetch_pkg::fetch_out_t  out_o,
  output fetch_pkg::imem_req_t   imem_req_o,
  input  fetch_pkg::imem_rsp_t   imem_rsp_i,
  output logic                   fetch_failed_o,
  output logic                   busy_o
);
  import fetch_pkg::*;

  localparam int unsigned USAGE_W = $clog2(FIFO_DEPTH + 1);

  typedef enum logic [2:0] {
    IDLE, WAIT_GNT, WAIT_RVALID, WAIT_ABORTED, WAIT_JUMP,
    WAIT_GNT_HWLOOP, WAIT_RVALID_HWLOOP, WAIT_ABORTED_HWLOOP
  } fetch_state_e;

  fetch_state_e       state_q, state_d;
  instr_addr_t        addr_q, fetch_addr, redir_addr, hwlp_target_q;
  logic               addr_valid, save_target;
  logic               start_fetch, out_valid, pass_valid;
  logic               fifo_push, fifo_pop, fifo_flush;
  logic               fifo_empty, fifo_full, fifo_valid, fifo_ready;
  logic [USAGE_W-1:0] fifo_usage;
  instr_data_t        fifo_rdata;

  assign busy_o = (state_q != IDLE) | imem_req_o.req;

  // next sequential word after the last issued address
  assign fetch_addr = {addr_q[31:2], 2'b00} + 32'd4;
  // a branch beats a loop jump, both beat sequential fetch
  assign redir_addr = branch_i      ? addr_i        :
                      hwlp_branch_i ? hwlp_target_i : fetch_addr;

  // keep one slot free per outstanding request, so no word is lost
  assign fifo_ready  = ~fifo_full & (fifo_usage < USAGE_W'(FIFO_DEPTH - 1));
  assign start_fetch = branch_i | hwlp_branch_i | (req_i & fifo_ready);

  ////////////////////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    imem_req_o     = '{req: 1'b0, addr: fetch_addr};
    state_d        = state_q;
    addr_valid     = 1'b0;
    save_target    = 1'b0;
    fifo_push      = 1'b0;
    fetch_failed_o = 1'b0;
    // everything queued behind an accepted loop end is stale too
    fifo_flush     = branch_i | hwlp_branch_i;

    unique case (state_q)
      // nothing outstanding
      IDLE: begin
        imem_req_o.addr = redir_addr;
        if (start_fetch) begin
          imem_req_o.req = 1'b1;
          addr_valid     = 1'b1;
          state_d        = imem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // stopped after an access error, only a redirect restarts fetching
      WAIT_JUMP: begin
        imem_req_o.addr = redir_addr;
        fetch_failed_o  = ~out_valid & ~branch_i;
        if (branch_i || hwlp_branch_i) begin
          imem_req_o.req = 1'b1;
          addr_valid     = 1'b1;
          state_d        = imem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // request held until granted, a branch may still retarget it
      WAIT_GNT: begin
        imem_req_o.req  = 1'b1;
        imem_req_o.addr = addr_q;
        if (branch_i) begin
          imem_req_o.addr = addr_i;
          addr_valid      = 1'b1;
        end
        if (hwlp_branch_i && !branch_i) begin
          // pending word lies past the loop end, drop it when it returns
          save_target = 1'b1;
          state_d     = imem_rsp_i.gnt ? WAIT_RVALID_HWLOOP : WAIT_GNT_HWLOOP;
        end else if (imem_rsp_i.gnt) begin
          state_d = WAIT_RVALID;
        end
      end

      WAIT_GNT_HWLOOP: begin
        imem_req_o.req  = 1'b1;
        imem_req_o.addr = addr_q;
        if (branch_i) begin
          imem_req_o.addr = addr_i;
          addr_valid      = 1'b1;
          state_d         = imem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end else if (imem_rsp_i.gnt) begin
          state_d = WAIT_RVALID_HWLOOP;
        end
      end

      // one word in flight, next request goes out with its rvalid
      WAIT_RVALID: begin
        imem_req_o.addr = redir_addr;
        if (imem_rsp_i.rvalid) begin
          // store unless it goes straight to the consumer
          fifo_push = ~imem_rsp_i.err & (fifo_valid | ~ready_i);
          if (imem_rsp_i.err && !branch_i && !hwlp_branch_i) begin
            state_d = WAIT_JUMP;
          end else if (start_fetch) begin
            imem_req_o.req = 1'b1;
            addr_valid     = 1'b1;
            state_d        = imem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
          end else begin
            state_d = IDLE;
          end
        end else if (branch_i) begin
          // remember the target, swallow the pending word first
          addr_valid = 1'b1;
          state_d    = WAIT_ABORTED;
        end else if (hwlp_branch_i) begin
          // loop end came from the FIFO, so the word in flight is past it
          save_target = 1'b1;
          state_d     = WAIT_ABORTED_HWLOOP;
        end
      end

      // pending word is stale, request the branch target once it arrives
      WAIT_ABORTED: begin
        imem_req_o.addr = addr_q;
        if (branch_i) begin
          imem_req_o.addr = addr_i;
          addr_valid      = 1'b1;
        end
        if (imem_rsp_i.rvalid) begin
          imem_req_o.req = 1'b1;
          addr_valid     = 1'b1;
          state_d        = imem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // same job as WAIT_ABORTED toward the saved loop start,
      // the two states differ only in how they were entered
      WAIT_RVALID_HWLOOP, WAIT_ABORTED_HWLOOP: begin
        imem_req_o.addr = branch_i ? addr_i : hwlp_target_q;
        if (imem_rsp_i.rvalid) begin
          imem_req_o.req = 1'b1;
          addr_valid     = 1'b1;
          state_d        = imem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end else if (branch_i) begin
          addr_valid = 1'b1;
          state_d    = WAIT_ABORTED;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_valid) addr_q <= imem_req_o.addr;
    end
  end

  always_ff @(posedge clk) begin
    if (save_target) hwlp_target_q <= hwlp_target_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // instruction queue and output
  ////////////////////////////////////////////////////////////////////////////

  instr_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_instr_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (fifo_flush),
    .push_i  (fifo_push),
    .pop_i   (fifo_pop),
    .data_i  (imem_rsp_i.rdata),
    .data_o  (fifo_rdata),
    .empty_o (fifo_empty),
    .full_o  (fifo_full),
    .usage_o (fifo_usage)
  );

  assign fifo_valid = ~fifo_empty;
  // fresh word bypasses the empty FIFO, never in an aborted state
  assign pass_valid = (state_q == WAIT_RVALID) & imem_rsp_i.rvalid & ~imem_rsp_i.err;
  // nothing is offered in a branch cycle, all of it is stale
  assign out_valid  = ~branch_i & (fifo_valid | pass_valid);
  assign fifo_pop   = fifo_valid & ready_i;

  assign out_o = '{valid: out_valid, rdata: fifo_valid ? fifo_rdata : imem_rsp_i.rdata};

endmodule

// ==== sources.f ====
hw/fetch_pkg.sv
hw/hwloop_pkg.sv
hw/instr_fifo.sv
hw/prefetch_buffer.sv
hw/hwloop_regs.sv
hw/fetch_top.sv
bench/fetch_top_tb.sv
